//--- rtl/vec_settings.svh
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

//////////////////////////////
// Data widths
//////////////////////////////
`define DATA_WIDTH    16        // One signed lane
`define WORD_WIDTH    32        // Two lanes per memory word
`define INST_WIDTH    32        // Opcode plus three address fields

//////////////////////////////
// Memory map and timing
//////////////////////////////
`define DM_ADDR_WIDTH 8         // 256 words per copy
`define RESULT_BASE   8'h40     // Readout stream starts here
`define WB_LATENCY    4         // Issue to write-back strobe, issue cycle counted

`endif

//--- rtl/vec_pkg.sv
`default_nettype none

package vec_pkg;

    // Opcode in inst[31:29]
    // 3'b100 and 3'b101 are unused, decoded as NOP
    typedef enum logic [2:0] {
        OP_NOP = 3'b000,        // Operands read, nothing written
        OP_ADD = 3'b001,        // Wrapping lane sum
        OP_SUB = 3'b010,        // Wrapping lane difference
        OP_XOR = 3'b011,        // Bitwise over the whole word
        OP_MIN = 3'b110,        // Signed lane minimum
        OP_MAX = 3'b111         // Signed lane maximum
    } op_t;

endpackage

`default_nettype wire

//--- rtl/sdp_bram.sv
`default_nettype none

`include "vec_settings.svh"

// Simple dual port, single clock
// Address in, read reg, output reg: data two edges after the address
module sdp_bram (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      wr_en,
    input  wire [`DM_ADDR_WIDTH-1:0] wr_addr,
    input  wire [`WORD_WIDTH-1:0]    wr_data,
    input  wire                      rd_en,
    input  wire [`DM_ADDR_WIDTH-1:0] rd_addr,
    output logic [`WORD_WIDTH-1:0]   rd_data
);

    logic [`WORD_WIDTH-1:0] mem [1 << `DM_ADDR_WIDTH];
    logic [`WORD_WIDTH-1:0] ram_q;      // Array read stage

    // Write port and array read
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            ram_q <= mem[rd_addr];      // Old data on same-address collision
    end

    // Output register, always enabled, cleared by reset
    always_ff @(posedge clk) begin
        if (rst)
            rd_data <= '0;
        else
            rd_data <= ram_q;
    end

endmodule

`default_nettype wire

//--- rtl/data_mem.sv
`default_nettype none

`include "vec_settings.svh"

// Data memory kept as three identical copies
// bank_a and bank_b give the two operands, bank_c feeds the readout
module data_mem (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      load_en,       // Load burst strobe
    input  wire [`WORD_WIDTH-1:0]    load_data,
    input  wire                      rd_ops_en,     // Operand read request
    input  wire [`DM_ADDR_WIDTH-1:0] src1_addr,
    input  wire [`DM_ADDR_WIDTH-1:0] src2_addr,
    input  wire [`DM_ADDR_WIDTH-1:0] dst_addr,
    input  wire                      wb_en,         // Write back
    input  wire [`WORD_WIDTH-1:0]    wb_data,
    input  wire                      rd_en,         // Readout stream request
    output logic [`WORD_WIDTH-1:0]   operand_a,
    output logic [`WORD_WIDTH-1:0]   operand_b,
    output logic [`WORD_WIDTH-1:0]   rd_data,
    output logic                     rd_valid
);

    logic [`DM_ADDR_WIDTH-1:0] load_ptr;            // Next load address
    logic [`DM_ADDR_WIDTH-1:0] load_waddr;
    logic [`WORD_WIDTH-1:0]    load_wdata;
    logic                      load_v;              // Registered load write
    logic [`DM_ADDR_WIDTH-1:0] src1_r, src2_r;
    logic                      ops_rd_r;
    logic [`DM_ADDR_WIDTH-1:0] dst_pipe [`WB_LATENCY];
    logic [`DM_ADDR_WIDTH-1:0] rd_ptr;              // Next readout address
    logic [`DM_ADDR_WIDTH-1:0] rd_addr_c;
    logic                      rd_req_r, rd_req_rr;
    logic                      wr_en;
    logic [`DM_ADDR_WIDTH-1:0] wr_addr;
    logic [`WORD_WIDTH-1:0]    wr_data;

    //////////////////////////////
    // Address counters and strobes
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            load_ptr  <= '0;
            load_v    <= 1'b0;
            ops_rd_r  <= 1'b0;
            rd_ptr    <= `RESULT_BASE;
            rd_req_r  <= 1'b0;
            rd_req_rr <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            load_v    <= load_en;
            load_ptr  <= load_en ? load_ptr + 1'b1 : '0;    // Burst restarts at 0
            ops_rd_r  <= rd_ops_en;                         // RAM read one cycle on
            rd_ptr    <= rd_en ? rd_ptr + 1'b1 : `RESULT_BASE;
            rd_req_r  <= rd_en;
            rd_req_rr <= rd_req_r;
            rd_valid  <= rd_req_rr;                         // Lines up with bank_c output
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        load_waddr <= load_ptr;
        load_wdata <= load_data;
        if (rd_ops_en) begin
            src1_r <= src1_addr;
            src2_r <= src2_addr;
        end
        rd_addr_c <= rd_ptr;
        // Destination rides along until the strobe
        dst_pipe[0] <= dst_addr;
        for (int i = 1; i < `WB_LATENCY; i++)
            dst_pipe[i] <= dst_pipe[i-1];
    end

    //////////////////////////////
    // Shared write port
    //////////////////////////////
    // Load wins, a write-back in the same cycle is lost
    assign wr_en   = load_v | wb_en;
    assign wr_addr = load_v ? load_waddr : dst_pipe[`WB_LATENCY-1];
    assign wr_data = load_v ? load_wdata : wb_data;

    sdp_bram bank_a (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (ops_rd_r),
        .rd_addr (src1_r),          // Source 1
        .rd_data (operand_a)
    );

    sdp_bram bank_b (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (ops_rd_r),
        .rd_addr (src2_r),          // Source 2
        .rd_data (operand_b)
    );

    sdp_bram bank_c (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_req_r),
        .rd_addr (rd_addr_c),       // Readout stream
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- rtl/inst_issuer.sv
`default_nettype none

`include "vec_settings.svh"

// Instruction input side
// Decodes, starts the operand read, tracks ops in flight
module inst_issuer
    import vec_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      inst_en,
    input  wire [`INST_WIDTH-1:0]    inst,
    output logic                     rd_ops_en,
    output logic [`DM_ADDR_WIDTH-1:0] src1_addr,
    output logic [`DM_ADDR_WIDTH-1:0] src2_addr,
    output logic [`DM_ADDR_WIDTH-1:0] dst_addr,
    output op_t                      alu_op,
    output logic                     wb_en
);

    op_t                    dec_op;
    logic [`WB_LATENCY-1:0] vld_pipe;                   // Bit i set i+1 edges after issue
    logic [`WB_LATENCY-1:0] wr_pipe;                    // Op writes back
    op_t                    op_pipe [`WB_LATENCY-1];

    // Opcode decode
    always_comb begin
        case (inst[31:29])
            OP_ADD, OP_SUB, OP_XOR, OP_MIN, OP_MAX:
                dec_op = op_t'(inst[31:29]);
            default:
                dec_op = OP_NOP;                        // Unused codes too
        endcase
    end

    // Fields straight to the memory, registered there
    assign rd_ops_en = inst_en;
    assign src2_addr = inst[23:16];
    assign src1_addr = inst[15:8];
    assign dst_addr  = inst[7:0];

    //////////////////////////////
    // In-flight tracking
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst)
            vld_pipe <= '0;
        else
            vld_pipe <= {vld_pipe[`WB_LATENCY-2:0], inst_en};
    end

    always_ff @(posedge clk) begin
        wr_pipe    <= {wr_pipe[`WB_LATENCY-2:0], dec_op != OP_NOP};
        op_pipe[0] <= dec_op;
        for (int i = 1; i < `WB_LATENCY - 1; i++)
            op_pipe[i] <= op_pipe[i-1];
    end

    // Operands land two edges after issue, ALU stage then
    assign alu_op = vld_pipe[`WB_LATENCY-2] ? op_pipe[`WB_LATENCY-2] : OP_NOP;

    // One cycle strobe, lined up with the ALU result
    assign wb_en = vld_pipe[`WB_LATENCY-1] & wr_pipe[`WB_LATENCY-1];

endmodule

`default_nettype wire

//--- rtl/lane_alu.sv
`default_nettype none

`include "vec_settings.svh"

// Two-lane ALU, one register stage
module lane_alu
    import vec_pkg::*;
(
    input  wire                    clk,
    input  wire [`WORD_WIDTH-1:0]  operand_a,
    input  wire [`WORD_WIDTH-1:0]  operand_b,
    input  wire op_t               alu_op,
    output logic [`WORD_WIDTH-1:0] alu_result
);

    // One lane, signed view for compares
    function automatic logic [`DATA_WIDTH-1:0] lane_op(
        input logic signed [`DATA_WIDTH-1:0] a,
        input logic signed [`DATA_WIDTH-1:0] b,
        input op_t                           op
    );
        case (op)
            OP_ADD:  lane_op = a + b;                   // Wraps
            OP_SUB:  lane_op = a - b;                   // Wraps
            OP_MAX:  lane_op = (a > b) ? a : b;
            OP_MIN:  lane_op = (a < b) ? a : b;
            OP_XOR:  lane_op = a ^ b;
            default: lane_op = '0;                      // NOP, never written
        endcase
    endfunction

    //////////////////////////////
    // Result register
    //////////////////////////////
    always_ff @(posedge clk) begin
        for (int i = 0; i < `WORD_WIDTH / `DATA_WIDTH; i++) begin
            // Lanes independent, no carry across
            alu_result[i*`DATA_WIDTH +: `DATA_WIDTH] <=
                lane_op(operand_a[i*`DATA_WIDTH +: `DATA_WIDTH],
                        operand_b[i*`DATA_WIDTH +: `DATA_WIDTH],
                        alu_op);
        end
    end

endmodule

`default_nettype wire

//--- rtl/vec_core.sv
`default_nettype none

`include "vec_settings.svh"

// Top level, issuer -> memory -> ALU -> memory
module vec_core
    import vec_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    load_en,
    input  wire [`WORD_WIDTH-1:0]  load_data,
    input  wire                    inst_en,
    input  wire [`INST_WIDTH-1:0]  inst,
    input  wire                    rd_en,
    output logic [`WORD_WIDTH-1:0] rd_data,
    output logic                   rd_valid
);

    logic                      rd_ops_en;
    logic [`DM_ADDR_WIDTH-1:0] src1_addr, src2_addr, dst_addr;
    logic [`WORD_WIDTH-1:0]    operand_a, operand_b;
    logic [`WORD_WIDTH-1:0]    alu_result;
    op_t                       alu_op;
    logic                      wb_en;               // Write back

    inst_issuer u_issuer (
        .clk       (clk),
        .rst       (rst),
        .inst_en   (inst_en),
        .inst      (inst),
        .rd_ops_en (rd_ops_en),
        .src1_addr (src1_addr),
        .src2_addr (src2_addr),
        .dst_addr  (dst_addr),
        .alu_op    (alu_op),
        .wb_en     (wb_en)
    );

    lane_alu u_alu (
        .clk        (clk),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    data_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_data (load_data),
        .rd_ops_en (rd_ops_en),
        .src1_addr (src1_addr),
        .src2_addr (src2_addr),
        .dst_addr  (dst_addr),
        .wb_en     (wb_en),
        .wb_data   (alu_result),
        .rd_en     (rd_en),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`default_nettype none

// Free running clock, 100 ns period
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #50 clk = ~clk;          // Half period

endmodule

`default_nettype wire

//--- dv/vec_core_chk.sv
`default_nettype none

`include "vec_settings.svh"

// Timing checks on the vec_core strobes
module vec_core_chk
    import vec_pkg::*;
(
    input wire                   clk,
    input wire                   rst,
    input wire                   load_en,
    input wire                   inst_en,
    input wire [`INST_WIDTH-1:0] inst,
    input wire                   rd_en,
    input wire                   rd_valid,
    input wire                   wb_en
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned err_count = 0;     // Failures so far
    logic        wr_issue;          // Issue of an op that writes back

    assign wr_issue = inst_en && (inst[31:29] inside {OP_ADD, OP_SUB, OP_XOR, OP_MIN, OP_MAX});

    //////////////////////////////
    // Write-back strobe
    //////////////////////////////
    wb_after_issue: assert property (@(posedge clk) disable iff (rst)
        $past(wr_issue, `WB_LATENCY) |-> wb_en)
        else begin err_count++; $error("wb_en missing after a writing issue"); end

    wb_only_from_issue: assert property (@(posedge clk) disable iff (rst)
        wb_en |-> $past(wr_issue, `WB_LATENCY))
        else begin err_count++; $error("wb_en without a matching issue"); end

    //////////////////////////////
    // Readout strobe
    //////////////////////////////
    // Raised two edges after the rd_en edge, so seen on the third
    valid_after_req: assert property (@(posedge clk) disable iff (rst)
        $past(rd_en, 3) |-> rd_valid)
        else begin err_count++; $error("rd_valid missing two cycles after rd_en"); end

    valid_only_from_req: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> $past(rd_en, 3))
        else begin err_count++; $error("rd_valid without rd_en two cycles before"); end

    // Quiet through reset and on the first edge after it
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> (!wb_en && !rd_valid))
        else begin err_count++; $error("strobe active in or just after reset"); end

    // Loads never meet a write-back
    no_load_clash: assert property (@(posedge clk) disable iff (rst)
        !(load_en && wb_en))
        else begin err_count++; $error("load_en high together with wb_en"); end

endmodule

bind vec_core vec_core_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .load_en  (load_en),
    .inst_en  (inst_en),
    .inst     (inst),
    .rd_en    (rd_en),
    .rd_valid (rd_valid),
    .wb_en    (wb_en)
);

`default_nettype wire

//--- dv/vec_core_tb.sv
`default_nettype none

`include "vec_settings.svh"

module vec_core_tb
    import vec_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_COPY  = 16;    // XOR copies into the result region
    localparam int N_ARITH = 32;    // Back-to-back arithmetic ops

    logic                      clk;
    logic                      rst;
    logic                      load_en;
    logic [`WORD_WIDTH-1:0]    load_data;
    logic                      inst_en;
    logic [`INST_WIDTH-1:0]    inst;
    logic                      rd_en;
    logic [`WORD_WIDTH-1:0]    rd_data;
    logic                      rd_valid;
    logic [`WORD_WIDTH-1:0]    ref_mem [1 << `DM_ADDR_WIDTH];   // Memory model

    tb_clock u_clock (.clk(clk));

    vec_core UUT (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_data (load_data),
        .inst_en   (inst_en),
        .inst      (inst),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic wait_edges(input int n);
        for (int i = 0; i < n; i++)
            @(posedge clk);
    endtask

    //////////////////////////////
    // Reference rules
    //////////////////////////////
    function automatic bit writes_back(input logic [2:0] code);
        return code inside {OP_ADD, OP_SUB, OP_XOR, OP_MIN, OP_MAX};
    endfunction

    function automatic logic [`WORD_WIDTH-1:0] expect_word(
        input logic [2:0]             code,
        input logic [`WORD_WIDTH-1:0] a,
        input logic [`WORD_WIDTH-1:0] b
    );
        logic [`WORD_WIDTH-1:0]        r;
        logic signed [`DATA_WIDTH-1:0] la;
        logic signed [`DATA_WIDTH-1:0] lb;
        r = '0;
        for (int l = 0; l < 2; l++) begin
            la = a[l*`DATA_WIDTH +: `DATA_WIDTH];
            lb = b[l*`DATA_WIDTH +: `DATA_WIDTH];
            case (code)
                OP_ADD:  r[l*`DATA_WIDTH +: `DATA_WIDTH] = la + lb;     // Carry out dropped
                OP_SUB:  r[l*`DATA_WIDTH +: `DATA_WIDTH] = la - lb;
                OP_MAX:  r[l*`DATA_WIDTH +: `DATA_WIDTH] = (la < lb) ? lb : la;
                OP_MIN:  r[l*`DATA_WIDTH +: `DATA_WIDTH] = (lb < la) ? lb : la;
                OP_XOR:  r[l*`DATA_WIDTH +: `DATA_WIDTH] = la ^ lb;
                default: r[l*`DATA_WIDTH +: `DATA_WIDTH] = '0;
            endcase
        end
        return r;
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic load_burst(input int n);
        logic [`WORD_WIDTH-1:0] w;
        for (int i = 0; i < n; i++) begin
            w = $urandom();
            @(posedge clk);
            load_en   <= 1'b1;
            load_data <= w;
            ref_mem[8'(i)] = w;                 // Burst starts at 0
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic issue(input logic [2:0] code, input logic [7:0] src1,
                         input logic [7:0] src2, input logic [7:0] dst);
        @(posedge clk);
        inst_en <= 1'b1;
        inst    <= {code, 5'b0, src2, src1, dst};
        if (writes_back(code))
            ref_mem[dst] = expect_word(code, ref_mem[src1], ref_mem[src2]);
    endtask

    // Close a burst and let the last result land
    task automatic end_issue();
        @(posedge clk);
        inst_en <= 1'b0;
        wait_edges(6);
    endtask

    task automatic read_stream(input int n);
        int                     got;
        int                     cyc;
        logic [7:0]             addr;
        logic [`WORD_WIDTH-1:0] exp_w;
        got = 0;
        cyc = 0;
        while (got < n) begin
            @(posedge clk);
            if (rd_valid) begin
                addr  = 8'(`RESULT_BASE + got);
                exp_w = ref_mem[addr];
                if (rd_data !== exp_w) begin
                    $display("mismatch at %0t ns: rd_data addr %0d got %h expected %h",
                             $time, addr, rd_data, exp_w);
                    abort_run("readout word differs from the model");
                end
                got++;
            end
            rd_en <= (cyc < n);             // Held for n cycles
            cyc++;
            if (cyc > n + 8)
                abort_run("timeout waiting for rd_valid");
        end
        // No strobes past the count
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (rd_valid)
                abort_run("rd_valid pulse beyond the requested count");
        end
    endtask

    always @(posedge clk) begin
        if (UUT.u_chk.err_count != 0)
            abort_run("bound assertion failed");
    end

    initial begin
        logic [7:0] src1;
        logic [7:0] src2;
        logic [2:0] code;
        logic [1:0] sel;
        void'($urandom(32'hf24efacd));
        rst       = 1'b1;
        load_en   = 1'b0;
        load_data = '0;
        inst_en   = 1'b0;
        inst      = '0;
        rd_en     = 1'b0;
        wait_edges(3);
        rst <= 1'b0;
        wait_edges(2);

        load_burst(64);

        // Zero word at the top then plain copies
        issue(OP_XOR, 8'h00, 8'h00, 8'hff);
        end_issue();
        for (int k = 0; k < N_COPY; k++) begin
            src1 = 8'($urandom_range(63, 0));
            issue(OP_XOR, src1, 8'hff, 8'(`RESULT_BASE + k));
        end
        end_issue();
        read_stream(N_COPY);

        // Back-to-back arithmetic
        for (int k = 0; k < N_ARITH; k++) begin
            sel  = 2'($urandom_range(3, 0));
            src1 = 8'($urandom_range(63, 0));
            src2 = 8'($urandom_range(63, 0));
            case (sel)
                2'd0:    code = OP_ADD;
                2'd1:    code = OP_SUB;
                2'd2:    code = OP_MAX;
                default: code = OP_MIN;
            endcase
            issue(code, src1, src2, 8'(`RESULT_BASE + N_COPY + k));
        end
        end_issue();
        read_stream(N_COPY + N_ARITH);

        // Unused codes and NOP over live results
        issue(3'b100, 8'h01, 8'h02, 8'(`RESULT_BASE));
        issue(3'b101, 8'h03, 8'h04, 8'(`RESULT_BASE + 1));
        issue(OP_NOP, 8'h05, 8'h06, 8'(`RESULT_BASE + 2));
        end_issue();
        read_stream(N_COPY + N_ARITH);      // Restarts at the base
        read_stream(5);

        @(negedge clk);                     // Checker results of the last edge
        if (UUT.u_chk.err_count != 0) begin
            abort_run("bound assertion failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
rtl/vec_pkg.sv
rtl/sdp_bram.sv
rtl/data_mem.sv
rtl/inst_issuer.sv
rtl/lane_alu.sv
rtl/vec_core.sv
dv/tb_clock.sv
dv/vec_core_chk.sv
dv/vec_core_tb.sv

//--- Makefile
# Verilator flow for the vec_core testbench
TOP := vec_core_tb

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f vlog.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 > run.log 2>&1 || true
	cat run.log
	@if grep -q "Simulation finished: FAIL" run.log; then \
		echo "Test failed, see run.log"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" run.log; then \
		echo "Run ended without a pass line, see run.log"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean
